// File: src/bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// data word and address width
`define WORD_W 32

// two cores share the RAM
`define NCORES 2

// words per data cache block
`define BLK_WORDS 2

// word select sits just above the byte offset
`define WOFF_BIT 2

`endif

// File: src/bus_pkg.sv
`include "bus_defines.svh"

`default_nettype none

package bus_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    typedef enum logic [1:0] {
        FREE,
        BUSY,
        ACCESS,
        ERROR
    } ramstate_t;

    typedef enum logic [3:0] {
        IDLE,
        SNOOP,
        CHECK,
        WB1,
        WB2,
        RD1,
        RD2,
        IREAD
    } bus_state_t;

    // answer from the snooped data cache
    typedef struct packed {
        logic trans;
        logic write;
    } snoop_rsp_t;

    typedef struct packed {
        logic core;
        logic write;
        logic active;
    } data_req_t;

    typedef struct packed {
        logic [`WORD_W-`WOFF_BIT-$clog2(`BLK_WORDS)-1:0] blk;
        logic [$clog2(`BLK_WORDS)-1:0]                   wsel;
        logic [`WOFF_BIT-1:0]                            boff;
    } daddr_fields_t;

    // same address, raw or split into block fields
    typedef union packed {
        word_t         raw;
        daddr_fields_t fld;
    } daddr_u;

endpackage

`default_nettype wire

// File: src/coherence_fsm.sv
`include "bus_defines.svh"

`default_nettype none

module coherence_fsm import bus_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  data_req_t          req,
    input  logic [`NCORES-1:0] iREN,
    input  snoop_rsp_t         rsp,
    input  ramstate_t          ramstate,
    output bus_state_t         state,
    output logic               icore,
    output logic               done
);

    bus_state_t next_state;
    logic       next_icore;
    logic       access;

    assign access = (ramstate == ACCESS);

    // last word of a fill or of a fetch
    assign done = access && (state == RD2 || state == IREAD);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            icore <= 1'b0;
        end else begin
            state <= next_state;
            icore <= next_icore;
        end
    end

    always_comb begin
        next_state = state;
        next_icore = icore;

        case (state)
            IDLE: begin
                // data requests win over fetches
                if (req.active) begin
                    next_state = SNOOP;
                end else if (iREN[0]) begin
                    next_state = IREAD;
                    next_icore = 1'b0;
                end else if (iREN[1]) begin
                    next_state = IREAD;
                    next_icore = 1'b1;
                end
            end

            SNOOP: begin
                next_state = CHECK;
            end

            CHECK: begin
                // dirty copy elsewhere goes back to RAM first
                if (rsp.trans && rsp.write) begin
                    next_state = WB1;
                end else begin
                    next_state = RD1;
                end
            end

            WB1: begin
                if (access) begin
                    next_state = WB2;
                end
            end

            WB2: begin
                if (access) begin
                    next_state = RD1;
                end
            end

            RD1: begin
                if (access) begin
                    next_state = RD2;
                end
            end

            RD2: begin
                if (access) begin
                    next_state = IDLE;
                end
            end

            IREAD: begin
                if (access) begin
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/request_select.sv
`include "bus_defines.svh"

`default_nettype none

module request_select import bus_pkg::*; (
    input  logic               CLK,
    input  logic               nRST,
    input  logic [`NCORES-1:0] dREN,
    input  logic [`NCORES-1:0] dWEN,
    input  bus_state_t         state,
    input  logic               done,
    output data_req_t          req
);

    data_req_t pick;
    data_req_t held;

    // lowest core index has priority
    always_comb begin
        pick = '0;
        for (int c = `NCORES - 1; c >= 0; c--) begin
            if (dREN[c] || dWEN[c]) begin
                pick.core   = c[0];
                pick.write  = dWEN[c];
                pick.active = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            held <= '0;
        end else if (done) begin
            held <= '0;
        end else if (state == IDLE) begin
            held <= pick;
        end
    end

    // live choice while idle, frozen once the bus is busy
    assign req = (state == IDLE) ? pick : held;

endmodule

`default_nettype wire

// File: src/snoop_unit.sv
`include "bus_defines.svh"

`default_nettype none

module snoop_unit import bus_pkg::*; (
    input  logic                CLK,
    input  logic                nRST,
    input  bus_state_t          state,
    input  data_req_t           req,
    input  word_t [`NCORES-1:0] daddr,
    input  logic [`NCORES-1:0]  cctrans,
    input  logic [`NCORES-1:0]  ccwrite,
    output logic [`NCORES-1:0]  ccwait,
    output logic [`NCORES-1:0]  ccinv,
    output word_t [`NCORES-1:0] ccsnoopaddr,
    output snoop_rsp_t          rsp
);

    logic   other;
    logic   snooping;
    daddr_u base;
    daddr_u partner;

    assign other = ~req.core;

    // other cache is frozen from snoop until the fill ends
    assign snooping = (state == SNOOP) || (state == CHECK) || (state == WB1) ||
                      (state == WB2) || (state == RD1) || (state == RD2);

    assign base.raw = daddr[req.core];

    always_comb begin
        partner.fld.blk  = base.fld.blk;
        partner.fld.wsel = ~base.fld.wsel;
        partner.fld.boff = base.fld.boff;
    end

    always_comb begin
        ccwait      = '0;
        ccinv       = '0;
        ccsnoopaddr = '0;

        if (snooping) begin
            ccwait[other] = 1'b1;
            // second write-back word is the partner
            ccsnoopaddr[other] = (state == WB2) ? partner.raw : base.raw;
            if (state == RD2 && req.write) begin
                ccinv[other] = 1'b1;
            end
        end
    end

    // sampled as SNOOP ends, so CHECK branches on a stable value
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rsp <= '0;
        end else if (state == SNOOP) begin
            rsp.trans <= cctrans[other];
            rsp.write <= ccwrite[other];
        end
    end

endmodule

`default_nettype wire

// File: src/ram_port_mux.sv
`include "bus_defines.svh"

`default_nettype none

module ram_port_mux import bus_pkg::*; (
    input  bus_state_t          state,
    input  data_req_t           req,
    input  logic                icore,
    input  word_t [`NCORES-1:0] iaddr,
    input  word_t [`NCORES-1:0] daddr,
    input  word_t [`NCORES-1:0] dstore,
    input  word_t               ramload,
    input  ramstate_t           ramstate,
    output logic                ramREN,
    output logic                ramWEN,
    output word_t               ramaddr,
    output word_t               ramstore,
    output word_t [`NCORES-1:0] iload,
    output word_t [`NCORES-1:0] dload,
    output logic [`NCORES-1:0]  iwait,
    output logic [`NCORES-1:0]  dwait
);

    logic   access;
    logic   other;
    daddr_u base;
    daddr_u partner;

    assign access = (ramstate == ACCESS);
    assign other  = ~req.core;

    assign base.raw = daddr[req.core];

    always_comb begin
        partner.fld.blk  = base.fld.blk;
        partner.fld.wsel = ~base.fld.wsel;
        partner.fld.boff = base.fld.boff;
    end

    always_comb begin
        ramREN   = 1'b0;
        ramWEN   = 1'b0;
        ramaddr  = '0;
        ramstore = '0;
        iload    = '0;
        dload    = '0;
        // every core waits unless its word is on the bus
        iwait    = '1;
        dwait    = '1;

        case (state)
            WB1, WB2: begin
                // snooped cache drives the word at ccsnoopaddr
                ramWEN   = 1'b1;
                ramaddr  = daddr[other];
                ramstore = dstore[other];
            end

            RD1: begin
                ramREN              = 1'b1;
                ramaddr             = base.raw;
                dload[req.core]     = ramload;
                dwait[req.core]     = !access;
            end

            RD2: begin
                ramREN              = 1'b1;
                ramaddr             = partner.raw;
                dload[req.core]     = ramload;
                dwait[req.core]     = !access;
            end

            IREAD: begin
                ramREN       = 1'b1;
                ramaddr      = iaddr[icore];
                iload[icore] = ramload;
                iwait[icore] = !access;
            end

            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/bus_controller.sv
`include "bus_defines.svh"

`default_nettype none

module bus_controller import bus_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,
    // core side
    input  logic [`NCORES-1:0]      iREN,
    input  logic [`NCORES-1:0]      dREN,
    input  logic [`NCORES-1:0]      dWEN,
    input  word_t [`NCORES-1:0]     iaddr,
    input  word_t [`NCORES-1:0]     daddr,
    input  word_t [`NCORES-1:0]     dstore,
    output logic [`NCORES-1:0]      iwait,
    output logic [`NCORES-1:0]      dwait,
    output word_t [`NCORES-1:0]     iload,
    output word_t [`NCORES-1:0]     dload,
    // snoop side
    input  logic [`NCORES-1:0]      cctrans,
    input  logic [`NCORES-1:0]      ccwrite,
    output logic [`NCORES-1:0]      ccwait,
    output logic [`NCORES-1:0]      ccinv,
    output word_t [`NCORES-1:0]     ccsnoopaddr,
    // ram side
    input  word_t                   ramload,
    input  ramstate_t               ramstate,
    output logic                    ramREN,
    output logic                    ramWEN,
    output word_t                   ramaddr,
    output word_t                   ramstore
);

    data_req_t  req;
    bus_state_t state;
    snoop_rsp_t rsp;
    logic       icore;
    logic       done;

    coherence_fsm u_fsm (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (req),
        .iREN     (iREN),
        .rsp      (rsp),
        .ramstate (ramstate),
        .state    (state),
        .icore    (icore),
        .done     (done)
    );

    request_select u_select (
        .CLK   (CLK),
        .nRST  (nRST),
        .dREN  (dREN),
        .dWEN  (dWEN),
        .state (state),
        .done  (done),
        .req   (req)
    );

    snoop_unit u_snoop (
        .CLK         (CLK),
        .nRST        (nRST),
        .state       (state),
        .req         (req),
        .daddr       (daddr),
        .cctrans     (cctrans),
        .ccwrite     (ccwrite),
        .ccwait      (ccwait),
        .ccinv       (ccinv),
        .ccsnoopaddr (ccsnoopaddr),
        .rsp         (rsp)
    );

    ram_port_mux u_mux (
        .state    (state),
        .req      (req),
        .icore    (icore),
        .iaddr    (iaddr),
        .daddr    (daddr),
        .dstore   (dstore),
        .ramload  (ramload),
        .ramstate (ramstate),
        .ramREN   (ramREN),
        .ramWEN   (ramWEN),
        .ramaddr  (ramaddr),
        .ramstore (ramstore),
        .iload    (iload),
        .dload    (dload),
        .iwait    (iwait),
        .dwait    (dwait)
    );

endmodule

`default_nettype wire

// File: test/ram_sim.sv
`include "bus_defines.svh"

`default_nettype none

module ram_sim import bus_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      ramREN,
    input  logic      ramWEN,
    input  word_t     ramaddr,
    input  word_t     ramstore,
    output word_t     ramload,
    output ramstate_t ramstate
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t      mem [256];
    logic [1:0] wait_cnt;

    function automatic word_t fill_word(word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    // pattern over the full byte address of each word
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(word_t'(i) << 2);
        end
    end

    // word is ready once the countdown runs out
    always_comb begin
        if (!(ramREN || ramWEN)) begin
            ramstate = FREE;
        end else if (wait_cnt == 2'd0) begin
            ramstate = ACCESS;
        end else begin
            ramstate = BUSY;
        end
    end

    assign ramload = mem[ramaddr[9:2]];

    // fresh latency of 1 to 4 cycles after each word and while free
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 2'd1;
        end else if (ramstate == BUSY) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            wait_cnt <= 2'($urandom_range(3, 0));
        end
    end

    always @(posedge CLK) begin
        if (ramstate == ACCESS && ramWEN) begin
            mem[ramaddr[9:2]] <= ramstore;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_bus_controller.sv
`include "bus_defines.svh"

`default_nettype none

module tb_bus_controller import bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    NTRANS = 400;
    localparam word_t BASE   = 32'h0000_0200;

    logic                CLK = 1'b0;
    logic                nRST;
    logic [`NCORES-1:0]  iREN, dREN, dWEN, iwait, dwait;
    logic [`NCORES-1:0]  cctrans, ccwrite, ccwait, ccinv;
    word_t [`NCORES-1:0] iaddr, daddr, dstore, iload, dload, ccsnoopaddr;
    word_t               ramload, ramaddr, ramstore;
    ramstate_t           ramstate;
    logic                ramREN, ramWEN;

    // shadow RAM and both data cache models with four blocks each
    word_t              shadow [256];
    logic               cvalid [`NCORES][4];
    logic               cdirty [`NCORES][4];
    word_t              cdata  [`NCORES][4][2];
    word_t              req_addr [`NCORES];
    logic [`NCORES-1:0] drop_d, drop_i;
    // data of core c is code c and its fetch is code 2 + c
    int                 order [$];
    int                 issued, words, wb_count;
    logic               exp_wb, inv_seen;

    bus_controller UUT (.*);
    ram_sim u_ram (.*);

    always #5 CLK = ~CLK;

    initial begin
        #(NTRANS * 40 * 10);
        $display("Timeout: the bus did not finish %0d transactions in time", NTRANS);
        $display("Verification failed");
        $fatal(1);
    end

    function automatic word_t fill_word(word_t a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic word_t partner_of(word_t a);
        return a ^ (word_t'(1) << `WOFF_BIT);
    endfunction

    function automatic int blk_of(word_t a);
        return int'(a[`WOFF_BIT+2:`WOFF_BIT+1]);
    endfunction

    function automatic int wsel_of(word_t a);
        return int'(a[`WOFF_BIT]);
    endfunction

    task automatic stop_on_error(string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_quiet();
        assert (!ramREN && !ramWEN && ccwait == '0 && ccinv == '0)
            else stop_on_error("bus lines active while no core requests");
    endtask

    // expectations for the request now at the head of the queue
    task automatic begin_transaction();
        int r;
        words = 0;
        wb_count = 0;
        inv_seen = 1'b0;
        exp_wb = 1'b0;
        if (order.size() > 0 && order[0] < 2) begin
            r = order[0];
            exp_wb = cvalid[1-r][blk_of(req_addr[r])] && cdirty[1-r][blk_of(req_addr[r])];
        end
    endtask

    task automatic start_round();
        int kind;
        for (int c = 0; c < `NCORES; c++) begin
            for (int b = 0; b < 4; b++) begin
                kind = $urandom_range(3, 0);
                cvalid[c][b] = (kind != 0);
                cdirty[c][b] = (kind == 3);
                cdata[c][b][0] = $urandom;
                cdata[c][b][1] = $urandom;
            end
        end
        for (int c = 0; c < `NCORES; c++) begin
            kind = $urandom_range(2, 0);
            req_addr[c] = BASE + ($urandom_range(7, 0) << 2);
            daddr[c] = req_addr[c];
            dREN[c] = (kind == 1);
            dWEN[c] = (kind == 2);
            if (kind != 0) begin
                order.push_back(c);
            end
        end
        for (int c = 0; c < `NCORES; c++) begin
            iaddr[c] = BASE + ($urandom_range(7, 0) << 2);
            iREN[c] = ($urandom_range(1, 0) == 1);
            if (iREN[c]) begin
                order.push_back(2 + c);
            end
        end
        if (order.size() == 0) begin
            iREN[0] = 1'b1;
            order.push_back(2);
        end
        issued += order.size();
        begin_transaction();
    endtask

    task automatic finish_data(int c);
        int b;
        b = blk_of(req_addr[c]);
        assert (wb_count == (exp_wb ? 2 : 0))
            else stop_on_error($sformatf("%0d write-back words for a miss", wb_count));
        assert (!dWEN[c] || (inv_seen && !cvalid[1-c][b]))
            else stop_on_error("write miss finished without invalidating the other copy");
        cvalid[c][b] = 1'b1;
        cdirty[c][b] = dWEN[c];
        drop_d[c] = 1'b1;
        void'(order.pop_front());
        begin_transaction();
    endtask

    // outputs sampled at the rising edge before any register moves
    task automatic sample_cycle();
        int    cur;
        int    r;
        int    b;
        word_t a;
        cur = order[0];
        r = cur % 2;
        b = blk_of(req_addr[r]);
        for (int c = 0; c < `NCORES; c++) begin
            if (ccinv[c]) begin
                assert (cur < 2 && dWEN[r] && c == 1 - r)
                    else stop_on_error("ccinv raised outside a write miss");
                // cache drops the block it is told to drop
                cvalid[c][blk_of(ccsnoopaddr[c])] = 1'b0;
                cdirty[c][blk_of(ccsnoopaddr[c])] = 1'b0;
                inv_seen = 1'b1;
            end
        end
        if (ramWEN && ramstate == ACCESS) begin
            a = (wb_count == 0) ? req_addr[r] : partner_of(req_addr[r]);
            assert (cur < 2 && exp_wb && wb_count < 2)
                else stop_on_error("RAM write without a modified copy to write back");
            assert (ramaddr == a && ramstore == cdata[1-r][b][wsel_of(a)])
                else stop_on_error($sformatf("write-back %h to %h, expected %h to %h",
                                             ramstore, ramaddr, cdata[1-r][b][wsel_of(a)], a));
            shadow[a[9:2]] = ramstore;
            wb_count++;
            if (wb_count == 2) begin
                cdirty[1-r][b] = 1'b0;
            end
        end
        for (int c = 0; c < `NCORES; c++) begin
            if (iREN[c] && !iwait[c]) begin
                assert (cur == 2 + c)
                    else stop_on_error($sformatf("fetch of core %0d served out of order", c));
                a = iaddr[c];
                assert (iload[c] == shadow[a[9:2]])
                    else stop_on_error($sformatf("iload %h at %h, expected %h",
                                                 iload[c], a, shadow[a[9:2]]));
                drop_i[c] = 1'b1;
                void'(order.pop_front());
                begin_transaction();
            end
            if ((dREN[c] || dWEN[c]) && !dwait[c]) begin
                assert (cur == c)
                    else stop_on_error($sformatf("data of core %0d served out of order", c));
                // requested word first and then its partner
                a = (words == 0) ? req_addr[c] : partner_of(req_addr[c]);
                assert (dload[c] == shadow[a[9:2]])
                    else stop_on_error($sformatf("dload %h at %h, expected %h",
                                                 dload[c], a, shadow[a[9:2]]));
                words++;
                if (words == 2) begin
                    finish_data(c);
                end
            end
        end
    endtask

    task automatic drive_inputs();
        word_t s;
        for (int c = 0; c < `NCORES; c++) begin
            if (drop_d[c]) begin
                dREN[c] = 1'b0;
                dWEN[c] = 1'b0;
                drop_d[c] = 1'b0;
            end
            if (drop_i[c]) begin
                iREN[c] = 1'b0;
                drop_i[c] = 1'b0;
            end
            // snooped cache answers and shows the addressed word on its port
            if (ccwait[c]) begin
                s = ccsnoopaddr[c];
                daddr[c] = s;
                dstore[c] = cdata[c][blk_of(s)][wsel_of(s)];
                cctrans[c] = cvalid[c][blk_of(s)];
                ccwrite[c] = cdirty[c][blk_of(s)];
            end else begin
                daddr[c] = req_addr[c];
                dstore[c] = '0;
                cctrans[c] = 1'b0;
                ccwrite[c] = 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(32'ha754));
        nRST = 1'b0;
        iREN = '0;
        dREN = '0;
        dWEN = '0;
        iaddr = '0;
        daddr = '0;
        dstore = '0;
        cctrans = '0;
        ccwrite = '0;
        drop_d = '0;
        drop_i = '0;
        issued = 0;
        for (int c = 0; c < `NCORES; c++) begin
            req_addr[c] = BASE;
        end
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(word_t'(i) << 2);
        end
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        while (issued < NTRANS) begin
            repeat (2) begin
                @(posedge CLK);
                check_quiet();
            end
            @(negedge CLK);
            start_round();
            while (order.size() > 0) begin
                @(posedge CLK);
                sample_cycle();
                @(negedge CLK);
                drive_inputs();
            end
        end

        @(posedge CLK);
        check_quiet();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
src/bus_pkg.sv
src/coherence_fsm.sv
src/request_select.sv
src/snoop_unit.sv
src/ram_port_mux.sv
src/bus_controller.sv
test/ram_sim.sv
test/tb_bus_controller.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bus_controller
SEED      ?= 1
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

SOURCES := $(wildcard src/*.sv src/*.svh test/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(OBJ_DIR)/V%: $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $* -Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from the search for the pass line
run: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) | \
		awk '{ print } /Verification passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
